// File: include/silver_params.svh
`ifndef SILVER_PARAMS_SVH
`define SILVER_PARAMS_SVH

`define SILVER_WORD_W 32
`define SILVER_RADDR_W 6
`define SILVER_NUM_REGS 64

// instruction field widths, packed msb first
`define SILVER_FUNC_W 4
`define SILVER_OPC_W 6
`define SILVER_CONST_W 23   // low constant field, also where LoadUpper splits the word
`define SILVER_UPPER_W 9    // upper constant, fills the bits above SILVER_CONST_W

`define SILVER_OPC_NORMAL 6'd0
`define SILVER_OPC_SHIFT 6'd1

`endif

// File: rtl/silver_pkg.sv
`include "silver_params.svh"

package silver_pkg;

   typedef enum logic [2:0] {
      kind_normal,
      kind_shift,
      kind_load_const,
      kind_load_upper,
      kind_illegal
   } op_kind_e;

   typedef enum logic [`SILVER_FUNC_W-1:0] {
      func_add, func_addc, func_sub, func_carry,
      func_overflow, func_inc, func_dec, func_mul,
      func_mulhu, func_and, func_or, func_xor,
      func_equal, func_less, func_lower, func_snd
   } alu_func_e;

   typedef struct packed {
      logic                       w_imm;   // set on a normal op makes it illegal
      logic [`SILVER_RADDR_W-1:0] rw;
      logic                       cls;     // constant class
      logic                       a_imm;
      logic [`SILVER_RADDR_W-1:0] ra;
      logic                       b_imm;
      logic [`SILVER_RADDR_W-1:0] rb;
      logic [`SILVER_FUNC_W-1:0]  func;
      logic [`SILVER_OPC_W-1:0]   opc;
   } alu_fmt_t;

   typedef struct packed {
      logic                       long_c;
      logic [`SILVER_RADDR_W-1:0] rw;
      logic                       cls;
      logic                       neg;
      logic [`SILVER_CONST_W-1:0] value;
   } const_fmt_t;

   // bit 24 picks the view
   typedef union packed {
      alu_fmt_t   alu_fmt;
      const_fmt_t const_fmt;
   } instr_u;

   // raw 6-bit immediate, sign-extended at operand select
   typedef struct packed {
      logic [`SILVER_RADDR_W-1:0] addr;
      logic                       from_reg;
      logic [`SILVER_RADDR_W-1:0] imm;
   } dec_opnd_t;

   typedef struct packed {
      op_kind_e                   kind;
      alu_func_e                  func;
      logic [`SILVER_RADDR_W-1:0] rw;
      dec_opnd_t                  a;
      dec_opnd_t                  b;
      dec_opnd_t                  w;
      logic [`SILVER_WORD_W-1:0]  cimm;
   } decoded_t;

   typedef struct packed {
      logic [`SILVER_RADDR_W-1:0] addr;
      logic                       from_reg;
      logic [`SILVER_WORD_W-1:0]  value;
   } opnd_t;

   typedef struct packed {
      logic                       valid;
      op_kind_e                   kind;
      alu_func_e                  func;
      logic [`SILVER_RADDR_W-1:0] rw;
      opnd_t                      a;
      opnd_t                      b;
      opnd_t                      w;
      logic [`SILVER_WORD_W-1:0]  cimm;
   } issue_t;

   typedef struct packed {
      logic                       valid;    // legal writeback
      logic                       illegal;
      logic [`SILVER_RADDR_W-1:0] rw;
      logic [`SILVER_WORD_W-1:0]  data;
   } result_t;

endpackage

// File: rtl/silver_decode.sv
`include "silver_params.svh"

module silver_decode (
   input  silver_pkg::instr_u   instr,
   output silver_pkg::decoded_t dec
);

   logic upper_ok;
   logic [`SILVER_WORD_W-1:0] const_val;

   // LoadUpper needs bits 23..9 clear
   assign upper_ok = ({instr.const_fmt.neg,
                       instr.const_fmt.value[`SILVER_CONST_W-1:`SILVER_UPPER_W]} == '0);

   assign const_val = {{`SILVER_UPPER_W{1'b0}}, instr.const_fmt.value};

   always_comb begin
      dec.func = silver_pkg::alu_func_e'(instr.alu_fmt.func);
      dec.rw   = instr.alu_fmt.rw;

      dec.a.addr     = instr.alu_fmt.ra;
      dec.a.from_reg = !instr.alu_fmt.a_imm;
      dec.a.imm      = instr.alu_fmt.ra;

      dec.b.addr     = instr.alu_fmt.rb;
      dec.b.from_reg = !instr.alu_fmt.b_imm;
      dec.b.imm      = instr.alu_fmt.rb;

      dec.w.addr     = instr.alu_fmt.rw;
      dec.w.from_reg = !instr.alu_fmt.w_imm;
      dec.w.imm      = instr.alu_fmt.rw;

      dec.kind = silver_pkg::kind_illegal;
      dec.cimm = '0;

      if (instr.const_fmt.cls) begin
         if (instr.const_fmt.long_c) begin
            dec.kind = silver_pkg::kind_load_const;
            dec.cimm = instr.const_fmt.neg ? ('0 - const_val) : const_val;
         end else if (upper_ok) begin
            dec.kind = silver_pkg::kind_load_upper;
            dec.cimm = {{`SILVER_CONST_W{1'b0}},
                        instr.const_fmt.value[`SILVER_UPPER_W-1:0]};
         end
      end else if (!instr.alu_fmt.w_imm) begin
         if (instr.alu_fmt.opc == `SILVER_OPC_NORMAL) begin
            dec.kind = silver_pkg::kind_normal;
         end else if (instr.alu_fmt.opc == `SILVER_OPC_SHIFT) begin
            dec.kind = silver_pkg::kind_shift;
         end
      end
   end

endmodule

// File: rtl/silver_operand_stage.sv
`include "silver_params.svh"

module silver_operand_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 instr_valid,
   input  silver_pkg::decoded_t dec,
   input  silver_pkg::result_t  wb,
   output silver_pkg::issue_t   issue
);

   logic [`SILVER_WORD_W-1:0] regs [`SILVER_NUM_REGS];
   logic [`SILVER_WORD_W-1:0] rd_a;
   logic [`SILVER_WORD_W-1:0] rd_b;
   logic [`SILVER_WORD_W-1:0] rd_w;
   silver_pkg::issue_t        issue_d;

   function automatic silver_pkg::opnd_t select_opnd(
      input silver_pkg::dec_opnd_t     d,
      input logic [`SILVER_WORD_W-1:0] rdata
   );
      silver_pkg::opnd_t o;
      o.addr     = d.addr;
      o.from_reg = d.from_reg;
      o.value    = d.from_reg ? rdata :
                   {{(`SILVER_WORD_W - `SILVER_RADDR_W){d.imm[`SILVER_RADDR_W-1]}}, d.imm};
      return o;
   endfunction

   // writeback in the same cycle bypasses the array
   assign rd_a = (wb.valid && wb.rw == dec.a.addr) ? wb.data : regs[dec.a.addr];
   assign rd_b = (wb.valid && wb.rw == dec.b.addr) ? wb.data : regs[dec.b.addr];
   assign rd_w = (wb.valid && wb.rw == dec.w.addr) ? wb.data : regs[dec.w.addr];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `SILVER_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.rw] <= wb.data;
      end
   end

   always_comb begin
      issue_d.valid = instr_valid;
      issue_d.kind  = dec.kind;
      issue_d.func  = dec.func;
      issue_d.rw    = dec.rw;
      issue_d.a     = select_opnd(dec.a, rd_a);
      issue_d.b     = select_opnd(dec.b, rd_b);
      issue_d.w     = select_opnd(dec.w, rd_w);
      issue_d.cimm  = dec.cimm;
   end

   always_ff @(posedge clk) begin
      issue <= issue_d;
      if (!rst_n) begin
         issue.valid <= 1'b0;   // payload keeps whatever it had
      end
   end

   // decoder must route the W field to the immediate for long constants
   a_const_w_imm: assert property (@(posedge clk) disable iff (!rst_n)
      issue.valid && issue.kind == silver_pkg::kind_load_const |-> !issue.w.from_reg);

endmodule

// File: rtl/silver_alu.sv
`include "silver_params.svh"

module silver_alu (
   input  silver_pkg::alu_func_e       func,
   input  logic [`SILVER_WORD_W-1:0]   a,
   input  logic [`SILVER_WORD_W-1:0]   b,
   input  logic                        carry_in,
   input  logic                        overflow_in,
   output logic [`SILVER_WORD_W-1:0]   res,
   output logic                        carry_out,
   output logic                        overflow_out
);

   localparam int W = `SILVER_WORD_W;

   logic [W:0]     sum;
   logic [W-1:0]   diff;
   logic [2*W-1:0] prod;

   assign sum  = {1'b0, a} + {1'b0, b} +
                 {{W{1'b0}}, carry_in & (func == silver_pkg::func_addc)};
   assign diff = a - b;
   assign prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};

   always_comb begin
      case (func)
         silver_pkg::func_add,
         silver_pkg::func_addc:     res = sum[W-1:0];
         silver_pkg::func_sub:      res = diff;
         silver_pkg::func_carry:    res = {{(W-1){1'b0}}, carry_in};
         silver_pkg::func_overflow: res = {{(W-1){1'b0}}, overflow_in};
         silver_pkg::func_inc:      res = a + 1'b1;
         silver_pkg::func_dec:      res = a - 1'b1;
         silver_pkg::func_mul:      res = prod[W-1:0];
         silver_pkg::func_mulhu:    res = prod[2*W-1:W];
         silver_pkg::func_and:      res = a & b;
         silver_pkg::func_or:       res = a | b;
         silver_pkg::func_xor:      res = a ^ b;
         silver_pkg::func_equal:    res = {{(W-1){1'b0}}, a == b};
         silver_pkg::func_less:     res = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
         silver_pkg::func_lower:    res = {{(W-1){1'b0}}, a < b};
         default:                   res = b;   // snd
      endcase
   end

   always_comb begin
      carry_out    = carry_in;
      overflow_out = overflow_in;
      case (func)
         silver_pkg::func_add: begin
            carry_out    = sum[W];
            overflow_out = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
         end
         silver_pkg::func_addc: begin
            carry_out = sum[W];
         end
         silver_pkg::func_sub: begin
            overflow_out = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
         end
         default: begin
            carry_out    = carry_in;   // flags held
            overflow_out = overflow_in;
         end
      endcase
   end

endmodule

// File: rtl/silver_execute.sv
`include "silver_params.svh"

module silver_execute (
   input  logic                clk,
   input  logic                rst_n,
   input  silver_pkg::issue_t  issue,
   output silver_pkg::result_t result
);

   localparam int W      = `SILVER_WORD_W;
   localparam int ROT_W  = $clog2(W);

   logic [W-1:0]   a_val;
   logic [W-1:0]   b_val;
   logic [W-1:0]   w_val;
   logic [W-1:0]   alu_res;
   logic [W-1:0]   shift_res;
   logic [W-1:0]   exe_data;
   logic [2*W-1:0] rot_pair;
   logic           carry_q;
   logic           overflow_q;
   logic           carry_d;
   logic           overflow_d;
   silver_pkg::result_t result_d;

   // previous result still sitting in the result register
   function automatic logic [W-1:0] forward(
      input silver_pkg::opnd_t   op,
      input silver_pkg::result_t r
   );
      if (op.from_reg && r.valid && !r.illegal && r.rw == op.addr) begin
         return r.data;
      end
      return op.value;
   endfunction

   assign a_val = forward(issue.a, result);
   assign b_val = forward(issue.b, result);
   assign w_val = forward(issue.w, result);

   silver_alu silver_alu_i (
      .func         (issue.func),
      .a            (a_val),
      .b            (b_val),
      .carry_in     (carry_q),
      .overflow_in  (overflow_q),
      .res          (alu_res),
      .carry_out    (carry_d),
      .overflow_out (overflow_d)
   );

   assign rot_pair = {a_val, a_val} >> b_val[ROT_W-1:0];

   always_comb begin
      case (issue.func[1:0])
         2'd0:    shift_res = a_val << b_val;
         2'd1:    shift_res = a_val >> b_val;
         2'd2:    shift_res = $unsigned($signed(a_val) >>> b_val);   // sign fill past 31
         default: shift_res = rot_pair[W-1:0];                       // rotate right
      endcase
   end

   always_comb begin
      case (issue.kind)
         silver_pkg::kind_normal:     exe_data = alu_res;
         silver_pkg::kind_shift:      exe_data = shift_res;
         silver_pkg::kind_load_const: exe_data = issue.cimm;
         silver_pkg::kind_load_upper:
            exe_data = {issue.cimm[`SILVER_UPPER_W-1:0], w_val[`SILVER_CONST_W-1:0]};
         default:                     exe_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         carry_q    <= 1'b0;
         overflow_q <= 1'b0;
      end else if (issue.valid && issue.kind == silver_pkg::kind_normal) begin
         carry_q    <= carry_d;
         overflow_q <= overflow_d;
      end
   end

   always_comb begin
      result_d.valid   = issue.valid && issue.kind != silver_pkg::kind_illegal;
      result_d.illegal = issue.valid && issue.kind == silver_pkg::kind_illegal;
      result_d.rw      = issue.rw;
      result_d.data    = exe_data;
   end

   always_ff @(posedge clk) begin
      result <= result_d;
      if (!rst_n) begin
         result.valid   <= 1'b0;
         result.illegal <= 1'b0;
      end
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      !(result.valid && result.illegal));

   a_illegal_src: assert property (@(posedge clk) disable iff (!rst_n)
      result.illegal |-> $past(issue.valid && issue.kind == silver_pkg::kind_illegal));

endmodule

// File: rtl/silver_core.sv
`include "silver_params.svh"

module silver_core (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        instr_valid,
   input  silver_pkg::instr_u          instr,
   output logic                        wb_valid,
   output logic [`SILVER_RADDR_W-1:0]  wb_addr,
   output logic [`SILVER_WORD_W-1:0]   wb_data,
   output logic                        illegal
);

   silver_pkg::decoded_t dec;
   silver_pkg::issue_t   issue;
   silver_pkg::result_t  result;

   silver_decode silver_decode_i (
      .instr (instr),
      .dec   (dec)
   );

   silver_operand_stage silver_operand_stage_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .dec         (dec),
      .wb          (result),
      .issue       (issue)
   );

   silver_execute silver_execute_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .issue  (issue),
      .result (result)
   );

   assign wb_valid = result.valid;
   assign wb_addr  = result.rw;
   assign wb_data  = result.data;
   assign illegal  = result.illegal;

endmodule

// File: test/silver_clock_gen.sv
module silver_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;   // released just after the fifth edge
   end

endmodule

// File: test/silver_checker.sv
`include "silver_params.svh"

module silver_checker (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       instr_valid,
   input  logic [`SILVER_WORD_W-1:0]  instr,
   input  logic                       wb_valid,
   input  logic [`SILVER_RADDR_W-1:0] wb_addr,
   input  logic [`SILVER_WORD_W-1:0]  wb_data,
   input  logic                       illegal,
   output int                         pending,
   output int                         checks,
   output int                         errors
);

   typedef struct packed {
      logic [31:0]                due;
      logic                       illegal;
      logic [`SILVER_RADDR_W-1:0] addr;
      logic [`SILVER_WORD_W-1:0]  data;
   } expect_t;

   logic [`SILVER_WORD_W-1:0] model_regs [`SILVER_NUM_REGS];
   logic                      model_carry;
   logic                      model_ovf;
   logic [31:0]               edge_cnt;
   expect_t                   exp_q [$];

   initial begin
      edge_cnt = 0;
      pending  = 0;
      checks   = 0;
      errors   = 0;
   end

   function automatic logic [31:0] sext6(input logic [5:0] v);
      return {{26{v[5]}}, v};
   endfunction

   // one instruction in program order, updates the model state
   function automatic expect_t predict(input logic [31:0] word);
      expect_t     e;
      logic [31:0] a;
      logic [31:0] b;
      logic [32:0] s;
      logic [63:0] p;
      logic [5:0]  rw;
      e      = '0;
      rw     = word[30:25];
      e.addr = rw;
      a = word[23] ? sext6(word[22:17]) : model_regs[word[22:17]];
      b = word[16] ? sext6(word[15:10]) : model_regs[word[15:10]];
      if (word[24]) begin
         if (word[31]) begin
            e.data = word[23] ? -{9'd0, word[22:0]} : {9'd0, word[22:0]};
         end else if (word[23:9] == 15'd0) begin
            e.data = {word[8:0], model_regs[rw][22:0]};   // upper 9 bits only
         end else begin
            e.illegal = 1'b1;
         end
      end else if (word[31] || word[5:0] > 6'd1) begin
         e.illegal = 1'b1;
      end else if (word[5:0] == 6'd1) begin
         case (word[7:6])
            2'd0:    e.data = (b >= 32) ? 32'd0 : a << b[4:0];
            2'd1:    e.data = (b >= 32) ? 32'd0 : a >> b[4:0];
            2'd2:    e.data = (b >= 32) ? {32{a[31]}} :
                              (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            default: e.data = (b[4:0] == 0) ? a : (a >> b[4:0]) | (a << (32 - b[4:0]));
         endcase
      end else begin
         p = {32'd0, a} * {32'd0, b};
         case (silver_pkg::alu_func_e'(word[9:6]))
            silver_pkg::func_add: begin
               s           = {1'b0, a} + {1'b0, b};
               e.data      = s[31:0];
               model_carry = s[32];
               model_ovf   = (a[31] == b[31]) && (s[31] != a[31]);
            end
            silver_pkg::func_addc: begin
               s           = {1'b0, a} + {1'b0, b} + {32'd0, model_carry};
               e.data      = s[31:0];
               model_carry = s[32];
            end
            silver_pkg::func_sub: begin
               e.data    = a - b;
               model_ovf = (a[31] != b[31]) && (e.data[31] != a[31]);
            end
            silver_pkg::func_carry:    e.data = {31'd0, model_carry};
            silver_pkg::func_overflow: e.data = {31'd0, model_ovf};
            silver_pkg::func_inc:      e.data = a + 1;
            silver_pkg::func_dec:      e.data = a - 1;
            silver_pkg::func_mul:      e.data = p[31:0];
            silver_pkg::func_mulhu:    e.data = p[63:32];
            silver_pkg::func_and:      e.data = a & b;
            silver_pkg::func_or:       e.data = a | b;
            silver_pkg::func_xor:      e.data = a ^ b;
            silver_pkg::func_equal:    e.data = {31'd0, a == b};
            silver_pkg::func_less:     e.data = {31'd0, $signed(a) < $signed(b)};
            silver_pkg::func_lower:    e.data = {31'd0, a < b};
            default:                   e.data = b;
         endcase
      end
      if (!e.illegal) begin
         model_regs[rw] = e.data;
      end
      return e;
   endfunction

   task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("ERROR %0t: %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      expect_t e;
      edge_cnt = edge_cnt + 1;
      if (!rst_n) begin
         for (int i = 0; i < `SILVER_NUM_REGS; i++) begin
            model_regs[i] = '0;
         end
         model_carry = 1'b0;
         model_ovf   = 1'b0;
         exp_q.delete();
      end else if (instr_valid) begin
         e     = predict(instr);
         e.due = edge_cnt + 1;   // visible in the cycle after the next edge
         exp_q.push_back(e);
      end
   end

   // outputs settle after the rising edge, so compare on the falling one
   always @(negedge clk) begin
      expect_t e;
      if (rst_n) begin
         if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
            e = exp_q.pop_front();
            checks++;
            if (e.illegal) begin
               if (illegal !== 1'b1) begin
                  $display("%0t: illegal word gave no illegal strobe", $time);
                  errors++;
               end
               check_field("wb_valid", 32'd0, {31'd0, wb_valid});
            end else if (wb_valid !== 1'b1) begin
               $display("%0t: missing writeback to r%0d", $time, e.addr);
               errors++;
            end else begin
               check_field("wb_addr", {26'd0, e.addr}, {26'd0, wb_addr});
               check_field("wb_data", e.data, wb_data);
               check_field("illegal", 32'd0, {31'd0, illegal});
            end
         end else if (wb_valid !== 1'b0 || illegal !== 1'b0) begin
            $display("%0t: strobe seen with no instruction due", $time);
            errors++;
         end
      end
      pending = exp_q.size();
   end

endmodule

// File: test/silver_tb.sv
`include "silver_params.svh"

module silver_tb;

   logic                       clk;
   logic                       rst_n;
   logic                       instr_valid;
   silver_pkg::instr_u         instr;
   logic                       wb_valid;
   logic [`SILVER_RADDR_W-1:0] wb_addr;
   logic [`SILVER_WORD_W-1:0]  wb_data;
   logic                       illegal;
   int                         pending;
   int                         checks;
   int                         errors;
   int                         timeouts;

   silver_clock_gen clock_gen_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   silver_core silver_core_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb_valid    (wb_valid),
      .wb_addr     (wb_addr),
      .wb_data     (wb_data),
      .illegal     (illegal)
   );

   silver_checker checker_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb_valid    (wb_valid),
      .wb_addr     (wb_addr),
      .wb_data     (wb_data),
      .illegal     (illegal),
      .pending     (pending),
      .checks      (checks),
      .errors      (errors)
   );

   function automatic logic [31:0] op_word(input logic [5:0] opc, input logic [3:0] func,
                                           input logic [5:0] rw, input logic a_imm,
                                           input logic [5:0] ra, input logic b_imm,
                                           input logic [5:0] rb);
      return {1'b0, rw, 1'b0, a_imm, ra, b_imm, rb, func, opc};
   endfunction

   function automatic logic [31:0] const_word(input logic [5:0] rw, input logic neg,
                                              input logic [22:0] value);
      return {1'b1, rw, 1'b1, neg, value};
   endfunction

   function automatic logic [31:0] upper_word(input logic [5:0] rw, input logic [8:0] imm);
      return {1'b0, rw, 1'b1, 15'd0, imm};
   endfunction

   // small register range so dependencies are frequent
   function automatic logic [31:0] random_legal();
      logic [31:0] w;
      int          sel;
      w   = $urandom;
      sel = $urandom % 8;
      w[30:25] = 6'($urandom % 8);
      w[22:17] = 6'($urandom % 8);
      w[15:10] = 6'($urandom % 8);
      if (sel < 6) begin
         w[31]   = 1'b0;
         w[24]   = 1'b0;
         w[5:0]  = (sel == 5) ? 6'd1 : 6'd0;
      end else begin
         w[31] = (sel == 6);
         w[24] = 1'b1;
         if (sel == 7) begin
            w[23:9] = '0;
         end
      end
      return w;
   endfunction

   task automatic send(input logic [31:0] word);
      instr_valid = 1'b1;
      instr       = word;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic run_directed();
      logic [5:0] amt [6];
      logic       amt_imm [6];
      amt     = '{6'h00, 6'h1f, 6'h05, 6'd3, 6'd5, 6'h3f};
      amt_imm = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
      for (int f = 0; f < 16; f++) begin
         send(op_word(6'd0, f[3:0], 6'(f), 1'b1, 6'h3b, 1'b1, 6'h07));
      end
      send(const_word(6'd1, 1'b0, 23'h123456));
      send(upper_word(6'd1, 9'h1ff));   // r1 negative
      send(const_word(6'd2, 1'b1, 23'h00beef));
      send(const_word(6'd3, 1'b0, 23'd32));
      send(const_word(6'd4, 1'b0, 23'd40));
      send(const_word(6'd5, 1'b0, 23'd64));
      send(const_word(6'd6, 1'b0, 23'h7fffff));
      send(upper_word(6'd6, 9'h0ff));   // r6 = 7fffffff
      idle(2);
      for (int f = 0; f < 16; f++) begin
         send(op_word(6'd0, f[3:0], 6'(20 + f), 1'b0, 6'd1, 1'b0, 6'd6));
         send(op_word(6'd0, f[3:0], 6'(40 + f), 1'b0, 6'd6, 1'b0, 6'd2));
      end
      for (int k = 0; k < 4; k++) begin
         for (int j = 0; j < 6; j++) begin
            send(op_word(6'd1, k[3:0], 6'd40, 1'b0, 6'd1, amt_imm[j], amt[j]));
            send(op_word(6'd1, k[3:0], 6'd41, 1'b0, 6'd6, amt_imm[j], amt[j]));
         end
      end
      // dependency chains on A, B and W
      for (int i = 0; i < 4; i++) begin
         send(op_word(6'd0, 4'd5, 6'd10, 1'b0, 6'd10, 1'b1, 6'd0));
      end
      for (int i = 0; i < 3; i++) begin
         send(op_word(6'd0, 4'd0, 6'd11, 1'b0, 6'd11, 1'b0, 6'd12));
         send(op_word(6'd0, 4'd7, 6'd12, 1'b0, 6'd12, 1'b0, 6'd11));
      end
      send(const_word(6'd13, 1'b0, 23'h7abcde));
      send(upper_word(6'd13, 9'h155));
      send(upper_word(6'd13, 9'h0aa));
      send(op_word(6'd0, 4'd9, 6'd14, 1'b0, 6'd13, 1'b0, 6'd1));
      send(op_word(6'd0, 4'd5, 6'd15, 1'b0, 6'd13, 1'b1, 6'd0));
      send(upper_word(6'd14, 9'h003));
      // flags
      send(op_word(6'd0, 4'd0, 6'd16, 1'b1, 6'h3f, 1'b1, 6'h01));
      send(op_word(6'd0, 4'd3, 6'd17, 1'b1, 6'h00, 1'b1, 6'h00));
      send(op_word(6'd0, 4'd1, 6'd18, 1'b1, 6'h00, 1'b1, 6'h00));
      send(op_word(6'd0, 4'd0, 6'd19, 1'b0, 6'd6, 1'b0, 6'd6));
      send(op_word(6'd0, 4'd4, 6'd17, 1'b1, 6'h00, 1'b1, 6'h00));
      send(op_word(6'd0, 4'd5, 6'd18, 1'b0, 6'd6, 1'b1, 6'h00));
      send(op_word(6'd0, 4'd2, 6'd19, 1'b0, 6'd2, 1'b0, 6'd6));
      send(op_word(6'd0, 4'd4, 6'd17, 1'b1, 6'h00, 1'b1, 6'h00));
      send(op_word(6'd0, 4'd3, 6'd18, 1'b1, 6'h00, 1'b1, 6'h00));
      // illegal words mixed with legal ones
      for (int opc = 2; opc <= 12; opc++) begin
         send(op_word(6'(opc), 4'd0, 6'd30, 1'b1, 6'd1, 1'b1, 6'd1));
         send(op_word(6'd0, 4'd5, 6'd30, 1'b0, 6'd30, 1'b1, 6'd0));
      end
      send(op_word(6'd0, 4'd0, 6'd31, 1'b1, 6'd1, 1'b1, 6'd1) | 32'h8000_0000);
      send(upper_word(6'd31, 9'h001) | 32'h0000_8000);
      send(op_word(6'd0, 4'd15, 6'd31, 1'b0, 6'd31, 1'b0, 6'd30));
      idle(3);
   endtask

   task automatic run_random(input int n);
      for (int i = 0; i < n; i++) begin
         send(random_legal());
         if ($urandom % 8 == 0) begin
            idle(1 + $urandom % 2);
         end
      end
   endtask

   task automatic finish_run();
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   initial begin
      int t;
      void'($urandom(32'h9fdf));
      instr_valid = 1'b0;
      instr       = '0;
      timeouts    = 0;
      for (t = 0; t < 20 && rst_n !== 1'b1; t++) begin
         @(posedge clk);
      end
      if (rst_n !== 1'b1) begin
         $display("reset was not released within 20 cycles");
         timeouts++;
      end else begin
         #1;
         run_directed();
         run_random(400);
         for (t = 0; t < 20 && pending != 0; t++) begin
            @(posedge clk);
         end
         if (pending != 0) begin
            $display("%0d instructions never produced an outcome", pending);
            timeouts++;
         end
         repeat (4) @(posedge clk);   // catch stray strobes
      end
      finish_run();
   end

endmodule

// File: flist.f
+incdir+include
rtl/silver_pkg.sv
rtl/silver_decode.sv
rtl/silver_operand_stage.sv
rtl/silver_alu.sv
rtl/silver_execute.sv
rtl/silver_core.sv
test/silver_clock_gen.sv
test/silver_checker.sv
test/silver_tb.sv

// File: Bender.yml
package:
  name: silver

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/silver_pkg.sv
      - rtl/silver_decode.sv
      - rtl/silver_operand_stage.sv
      - rtl/silver_alu.sv
      - rtl/silver_execute.sv
      - rtl/silver_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/silver_clock_gen.sv
      - test/silver_checker.sv
      - test/silver_tb.sv
